// File: hdl/vertex_macros.svh
`ifndef VERTEX_MACROS_SVH
`define VERTEX_MACROS_SVH

// one element of the degree or edge index arrays
`define VTX_WORD_BITS 32

// cache line geometry
`define VTX_PER_LINE 4
`define VTX_LINE_BITS 128
`define VTX_LINE_BYTES 16

// byte address width on the memory side
`define VTX_ADDR_BITS 32

// vertex ids and counts
`define VTX_COUNT_BITS 16

// job queue entries, power of two
`define VTX_FIFO_DEPTH 16

`endif

// File: hdl/mem_cmd_pkg.sv
`include "vertex_macros.svh"

package mem_cmd_pkg;

	typedef logic [`VTX_ADDR_BITS-1:0] addr_t;
	typedef logic [`VTX_LINE_BITS-1:0] line_t;
	typedef logic [7:0] byte_size_t;

	// which array a command or a returned line belongs to
	typedef enum logic {
		INV_OUT_DEGREE = 1'b0,
		INV_EDGES_IDX  = 1'b1
	} array_tag_e;

	// cached full line or uncached exact byte count
	typedef enum logic {
		READ_CL      = 1'b0,
		READ_PARTIAL = 1'b1
	} read_kind_e;

	typedef struct packed {
		addr_t      addr;
		byte_size_t size;
		read_kind_e kind;
		array_tag_e tag;
	} mem_cmd_t;

	typedef struct packed {
		array_tag_e tag;
		line_t      line;
	} mem_data_t;

endpackage

// File: hdl/vertex_job_pkg.sv
`include "vertex_macros.svh"

package vertex_job_pkg;

	typedef logic [`VTX_WORD_BITS-1:0] vtx_word_t;
	typedef logic [`VTX_COUNT_BITS-1:0] vtx_count_t;

	typedef struct packed {
		mem_cmd_pkg::addr_t degree_base;
		mem_cmd_pkg::addr_t edges_base;
		vtx_count_t         count;
		vtx_count_t         first_id;
		logic               cached;
	} job_desc_t;

	// vertices carried by one line pair
	typedef struct packed {
		vtx_count_t first_id;
		vtx_count_t count;
	} batch_t;

	typedef struct packed {
		vtx_count_t id;
		vtx_word_t  inv_out_degree;
		vtx_word_t  inv_edges_idx;
	} vertex_job_t;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_WAIT_ROOM,
		SEQ_CMD_DEGREE,
		SEQ_CMD_EDGES,
		SEQ_WAIT_BATCH
	} seq_state_e;

endpackage

// File: hdl/vertex_read_sequencer.sv
`include "vertex_macros.svh"

module vertex_read_sequencer (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       job_start,
	input  vertex_job_pkg::job_desc_t  job,
	input  logic                       cmd_grant,
	input  vertex_job_pkg::vtx_count_t free,
	input  logic                       batch_done,
	output logic                       cmd_req,
	output mem_cmd_pkg::mem_cmd_t      cmd,
	output logic                       batch_load,
	output vertex_job_pkg::batch_t     batch,
	output logic                       busy
);

	vertex_job_pkg::seq_state_e state;
	vertex_job_pkg::job_desc_t  job_q;
	vertex_job_pkg::vtx_count_t remaining;
	vertex_job_pkg::vtx_count_t next_id;
	vertex_job_pkg::vtx_count_t line_cnt;
	mem_cmd_pkg::addr_t         offset;
	logic                       room;
	logic                       full_line;

	assign full_line = remaining >= vertex_job_pkg::vtx_count_t'(`VTX_PER_LINE);
	assign line_cnt  = full_line ? vertex_job_pkg::vtx_count_t'(`VTX_PER_LINE) : remaining;
	// a whole line must fit before the next pair goes out
	assign room      = free >= vertex_job_pkg::vtx_count_t'(`VTX_PER_LINE);
	assign busy      = state != vertex_job_pkg::SEQ_IDLE;

	assign batch.first_id = next_id;
	assign batch.count    = line_cnt;

	//////////////////////////////
	// line stepping fsm
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state      <= vertex_job_pkg::SEQ_IDLE;
			cmd_req    <= 1'b0;
			batch_load <= 1'b0;
			remaining  <= '0;
			next_id    <= '0;
			offset     <= '0;
		end else begin
			batch_load <= 1'b0;
			case (state)
				vertex_job_pkg::SEQ_IDLE: begin
					if (job_start) begin
						remaining <= job.count;
						next_id   <= job.first_id;
						offset    <= '0;
						state     <= vertex_job_pkg::SEQ_WAIT_ROOM;
					end
				end
				vertex_job_pkg::SEQ_WAIT_ROOM: begin
					if (remaining == '0) begin
						state <= vertex_job_pkg::SEQ_IDLE;
					end else if (room) begin
						cmd_req    <= 1'b1;
						batch_load <= 1'b1;
						state      <= vertex_job_pkg::SEQ_CMD_DEGREE;
					end
				end
				vertex_job_pkg::SEQ_CMD_DEGREE: begin
					if (cmd_grant) begin
						cmd_req <= 1'b0;
						state   <= vertex_job_pkg::SEQ_CMD_EDGES;
					end
				end
				vertex_job_pkg::SEQ_CMD_EDGES: begin
					// request is low for one cycle after the degree grant
					if (!cmd_req) begin
						cmd_req <= 1'b1;
					end else if (cmd_grant) begin
						cmd_req   <= 1'b0;
						remaining <= remaining - line_cnt;
						next_id   <= next_id + line_cnt;
						offset    <= offset + mem_cmd_pkg::addr_t'(`VTX_LINE_BYTES);
						state     <= vertex_job_pkg::SEQ_WAIT_BATCH;
					end
				end
				vertex_job_pkg::SEQ_WAIT_BATCH: begin
					if (batch_done) begin
						if (remaining == '0)
							state <= vertex_job_pkg::SEQ_IDLE;
						else
							state <= vertex_job_pkg::SEQ_WAIT_ROOM;
					end
				end
				default: state <= vertex_job_pkg::SEQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == vertex_job_pkg::SEQ_IDLE && job_start)
			job_q <= job;
	end

	//////////////////////////////
	// command fields
	//////////////////////////////

	always_comb begin
		if (state == vertex_job_pkg::SEQ_CMD_EDGES) begin
			cmd.tag  = mem_cmd_pkg::INV_EDGES_IDX;
			cmd.addr = job_q.edges_base + offset;
		end else begin
			cmd.tag  = mem_cmd_pkg::INV_OUT_DEGREE;
			cmd.addr = job_q.degree_base + offset;
		end
		if (job_q.cached) begin
			cmd.kind = mem_cmd_pkg::READ_CL;
			cmd.size = mem_cmd_pkg::byte_size_t'(`VTX_LINE_BYTES);
		end else if (full_line) begin
			cmd.kind = mem_cmd_pkg::READ_PARTIAL;
			cmd.size = mem_cmd_pkg::byte_size_t'(`VTX_LINE_BYTES);
		end else begin
			// four bytes per vertex left in the tail line
			cmd.kind = mem_cmd_pkg::READ_PARTIAL;
			cmd.size = mem_cmd_pkg::byte_size_t'(remaining << 2);
		end
	end

endmodule

// File: hdl/vertex_line_unpacker.sv
`include "vertex_macros.svh"

module vertex_line_unpacker (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        batch_load,
	input  vertex_job_pkg::batch_t      batch,
	input  logic                        mem_data_valid,
	input  mem_cmd_pkg::mem_data_t      mem_data,
	output logic                        push,
	output vertex_job_pkg::vertex_job_t push_job,
	output logic                        batch_done
);

	mem_cmd_pkg::line_t         degree_line;
	mem_cmd_pkg::line_t         edges_line;
	logic                       have_degree;
	logic                       have_edges;
	vertex_job_pkg::vtx_count_t count;
	vertex_job_pkg::vtx_count_t id;

	// one vertex per cycle once both lines are in
	assign push       = have_degree && have_edges && (count != '0);
	assign batch_done = push && (count == vertex_job_pkg::vtx_count_t'(1));

	assign push_job.id             = id;
	assign push_job.inv_out_degree = degree_line[`VTX_WORD_BITS-1:0];
	assign push_job.inv_edges_idx  = edges_line[`VTX_WORD_BITS-1:0];

	//////////////////////////////
	// arrival flags and count
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			have_degree <= 1'b0;
			have_edges  <= 1'b0;
			count       <= '0;
		end else begin
			if (batch_load) begin
				have_degree <= 1'b0;
				have_edges  <= 1'b0;
				count       <= batch.count;
			end else if (push) begin
				count <= count - 1'b1;
			end
			if (mem_data_valid) begin
				if (mem_data.tag == mem_cmd_pkg::INV_EDGES_IDX)
					have_edges <= 1'b1;
				else
					have_degree <= 1'b1;
			end
		end
	end

	//////////////////////////////
	// line registers
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (batch_load)
			id <= batch.first_id;
		else if (push)
			id <= id + 1'b1;

		// lowest word goes first, so shift right each push
		if (mem_data_valid && mem_data.tag == mem_cmd_pkg::INV_OUT_DEGREE)
			degree_line <= mem_data.line;
		else if (push)
			degree_line <= degree_line >> `VTX_WORD_BITS;

		if (mem_data_valid && mem_data.tag == mem_cmd_pkg::INV_EDGES_IDX)
			edges_line <= mem_data.line;
		else if (push)
			edges_line <= edges_line >> `VTX_WORD_BITS;
	end

endmodule

// File: hdl/vertex_job_fifo.sv
`include "vertex_macros.svh"

module vertex_job_fifo (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        push,
	input  vertex_job_pkg::vertex_job_t push_job,
	input  logic                        vertex_request,
	output logic                        vertex_valid,
	output vertex_job_pkg::vertex_job_t vertex,
	output vertex_job_pkg::vtx_count_t  free
);

	localparam int PTR_BITS = $clog2(`VTX_FIFO_DEPTH);

	vertex_job_pkg::vertex_job_t mem [`VTX_FIFO_DEPTH];
	logic [PTR_BITS-1:0]         wr_ptr;
	logic [PTR_BITS-1:0]         rd_ptr;
	logic [PTR_BITS:0]           occ;
	logic                        wr_en;
	logic                        rd_en;

	assign wr_en = push && (occ != (PTR_BITS + 1)'(`VTX_FIFO_DEPTH));
	// a request on an empty queue is dropped
	assign rd_en = vertex_request && (occ != '0);
	assign free  = vertex_job_pkg::vtx_count_t'(`VTX_FIFO_DEPTH) - vertex_job_pkg::vtx_count_t'(occ);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			occ          <= '0;
			vertex_valid <= 1'b0;
		end else begin
			vertex_valid <= rd_en;
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   occ <= occ + 1'b1;
				2'b01:   occ <= occ - 1'b1;
				default: occ <= occ;
			endcase
		end
	end

	// storage and output word
	always_ff @(posedge clock) begin
		if (wr_en)
			mem[wr_ptr] <= push_job;
		if (rd_en)
			vertex <= mem[rd_ptr];
	end

endmodule

// File: hdl/cu_vertex_job_control.sv
module cu_vertex_job_control (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        job_start,
	input  vertex_job_pkg::job_desc_t   job,
	output logic                        cmd_req,
	output mem_cmd_pkg::mem_cmd_t       cmd,
	input  logic                        cmd_grant,
	input  logic                        mem_data_valid,
	input  mem_cmd_pkg::mem_data_t      mem_data,
	input  logic                        vertex_request,
	output logic                        vertex_valid,
	output vertex_job_pkg::vertex_job_t vertex,
	output logic                        busy
);

	logic                        batch_load;
	vertex_job_pkg::batch_t      batch;
	logic                        batch_done;
	logic                        push;
	vertex_job_pkg::vertex_job_t push_job;
	vertex_job_pkg::vtx_count_t  free;

	// paired line reads, gated by queue room
	vertex_read_sequencer seq0 (
		.clock      (clock),
		.rstn       (rstn),
		.job_start  (job_start),
		.job        (job),
		.cmd_grant  (cmd_grant),
		.free       (free),
		.batch_done (batch_done),
		.cmd_req    (cmd_req),
		.cmd        (cmd),
		.batch_load (batch_load),
		.batch      (batch),
		.busy       (busy)
	);

	vertex_line_unpacker unpack0 (
		.clock          (clock),
		.rstn           (rstn),
		.batch_load     (batch_load),
		.batch          (batch),
		.mem_data_valid (mem_data_valid),
		.mem_data       (mem_data),
		.push           (push),
		.push_job       (push_job),
		.batch_done     (batch_done)
	);

	vertex_job_fifo fifo0 (
		.clock          (clock),
		.rstn           (rstn),
		.push           (push),
		.push_job       (push_job),
		.vertex_request (vertex_request),
		.vertex_valid   (vertex_valid),
		.vertex         (vertex),
		.free           (free)
	);

endmodule

// File: test/tb_vertex_job_control.sv
`include "vertex_macros.svh"

module tb_vertex_job_control;

	timeunit 1ns;
	timeprecision 100ps;

	logic                        clock;
	logic                        rstn;
	logic                        job_start;
	vertex_job_pkg::job_desc_t   job;
	logic                        cmd_req;
	mem_cmd_pkg::mem_cmd_t       cmd;
	logic                        cmd_grant;
	logic                        mem_data_valid;
	mem_cmd_pkg::mem_data_t      mem_data;
	logic                        vertex_request;
	logic                        vertex_valid;
	vertex_job_pkg::vertex_job_t vertex;
	logic                        busy;

	// memory image and jobs from the stim file
	vertex_job_pkg::vtx_word_t   mem_words [mem_cmd_pkg::addr_t];
	vertex_job_pkg::job_desc_t   jobs [$];
	mem_cmd_pkg::mem_cmd_t       exp_cmds [$];
	vertex_job_pkg::vertex_job_t exp_vertices [$];
	int                          line_counts [$];
	mem_cmd_pkg::mem_data_t      beats [$];
	mem_cmd_pkg::mem_data_t      held_degree;
	logic                        grant_armed;
	logic                        reverse_data;
	logic                        busy_last;
	int                          grant_delay;
	int                          issued;
	int                          popped;
	int                          stall_cycles;
	int                          cycles;
	int                          cycle_limit;

	cu_vertex_job_control dut0 (.*);

	always #4 clock = ~clock;

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_cmd(input mem_cmd_pkg::mem_cmd_t expected, input string name);
		if (cmd !== expected)
			stop_on_error($sformatf("MISMATCH at %0t: %s expected %h got %h",
				$time, name, expected, cmd));
	endtask

	task automatic check_vertex(input vertex_job_pkg::vertex_job_t expected, input string name);
		if (vertex !== expected)
			stop_on_error($sformatf("MISMATCH at %0t: %s expected %h got %h",
				$time, name, expected, vertex));
	endtask

	// words missing from the file read as a pattern of their whole address
	function automatic mem_cmd_pkg::line_t read_line(input mem_cmd_pkg::addr_t addr);
		mem_cmd_pkg::line_t line;
		mem_cmd_pkg::addr_t a;
		int                 w;
		for (w = 0; w < 4; w++) begin
			a = addr + mem_cmd_pkg::addr_t'(4 * w);
			if (mem_words.exists(a))
				line[32 * w +: 32] = mem_words[a];
			else
				line[32 * w +: 32] = a ^ {a[15:0], a[31:16]} ^ 32'hc3a5_5a3c;
		end
		return line;
	endfunction

	task automatic load_stim();
		int                         fd;
		int                         n;
		int                         w;
		string                      text;
		mem_cmd_pkg::addr_t         addr;
		mem_cmd_pkg::addr_t         edges;
		mem_cmd_pkg::line_t         line;
		vertex_job_pkg::vtx_count_t count;
		vertex_job_pkg::vtx_count_t first;
		logic                       cached;
		vertex_job_pkg::job_desc_t  d;
		fd = $fopen("test/vertex_stim.txt", "r");
		if (fd == 0)
			stop_on_error("cannot open test/vertex_stim.txt");
		while (!$feof(fd)) begin
			n = $fgets(text, fd);
			if (n > 0 && text[0] == "M") begin
				n = $sscanf(text, "M %h %h", addr, line);
				for (w = 0; w < 4; w++)
					mem_words[addr + mem_cmd_pkg::addr_t'(4 * w)] = line[32 * w +: 32];
			end else if (n > 0 && text[0] == "J") begin
				n = $sscanf(text, "J %h %h %h %h %h", addr, edges, count, first, cached);
				d.degree_base = addr;
				d.edges_base  = edges;
				d.count       = count;
				d.first_id    = first;
				d.cached      = cached;
				jobs.push_back(d);
			end
		end
		$fclose(fd);
	endtask

	////////////////////////////////
	// expected traffic per job
	////////////////////////////////

	task automatic build_expected(input vertex_job_pkg::job_desc_t d);
		int                          i;
		int                          left;
		mem_cmd_pkg::mem_cmd_t       c;
		vertex_job_pkg::vertex_job_t v;
		mem_cmd_pkg::line_t          deg_line;
		mem_cmd_pkg::line_t          edg_line;
		for (i = 0; i < int'(d.count); i += 4) begin
			left   = int'(d.count) - i;
			c.kind = d.cached ? mem_cmd_pkg::READ_CL : mem_cmd_pkg::READ_PARTIAL;
			c.size = (d.cached || left >= 4) ? 8'd16 : 8'(4 * left);
			line_counts.push_back((left >= 4) ? 4 : left);
			c.tag  = mem_cmd_pkg::INV_OUT_DEGREE;
			c.addr = d.degree_base + mem_cmd_pkg::addr_t'(16 * (i / 4));
			exp_cmds.push_back(c);
			c.tag  = mem_cmd_pkg::INV_EDGES_IDX;
			c.addr = d.edges_base + mem_cmd_pkg::addr_t'(16 * (i / 4));
			exp_cmds.push_back(c);
		end
		for (i = 0; i < int'(d.count); i++) begin
			deg_line         = read_line(d.degree_base + mem_cmd_pkg::addr_t'(16 * (i / 4)));
			edg_line         = read_line(d.edges_base + mem_cmd_pkg::addr_t'(16 * (i / 4)));
			v.id             = d.first_id + vertex_job_pkg::vtx_count_t'(i);
			v.inv_out_degree = deg_line[32 * (i % 4) +: 32];
			v.inv_edges_idx  = edg_line[32 * (i % 4) +: 32];
			exp_vertices.push_back(v);
		end
	endtask

	task automatic take_command();
		mem_cmd_pkg::mem_data_t beat;
		if (exp_cmds.size() == 0)
			stop_on_error("a command was issued when none was expected");
		check_cmd(exp_cmds.pop_front(), "cmd");
		beat.tag  = cmd.tag;
		beat.line = read_line(cmd.addr);
		if (cmd.tag == mem_cmd_pkg::INV_OUT_DEGREE) begin
			// a new line needs room for four more vertices
			if (issued - popped > `VTX_FIFO_DEPTH - `VTX_PER_LINE)
				stop_on_error($sformatf("line issued with %0d vertices in flight",
					issued - popped));
			issued += line_counts.pop_front();
			held_degree = beat;
		end else if (reverse_data || $urandom % 2 == 1) begin
			beats.push_back(beat);
			beats.push_back(held_degree);
		end else begin
			beats.push_back(held_degree);
			beats.push_back(beat);
		end
	endtask

	task automatic step_cycle();
		@(negedge clock);
		cycles++;
		if (cycles >= cycle_limit)
			stop_on_error($sformatf("run timed out after %0d cycles", cycles));
		if (vertex_valid) begin
			if (!vertex_request)
				stop_on_error("vertex_valid came without a vertex_request the cycle before");
			if (exp_vertices.size() == 0)
				stop_on_error("vertex_valid came with no vertex left to expect");
			check_vertex(exp_vertices.pop_front(), "vertex");
			popped++;
		end
		vertex_request = (stall_cycles == 0) && ($urandom % 2 == 1);
		if (stall_cycles > 0)
			stall_cycles--;
		// memory side
		mem_data_valid = 1'b0;
		if (cmd_grant) begin
			cmd_grant   = 1'b0;
			grant_armed = 1'b0;
			if (cmd_req)
				stop_on_error("cmd_req stayed high in the cycle after its grant");
		end else if (cmd_req) begin
			if (!grant_armed)
				grant_delay = $urandom % 6;
			grant_armed = 1'b1;
			if (grant_delay == 0) begin
				take_command();
				cmd_grant = 1'b1;
			end else begin
				grant_delay--;
			end
		end
		if (beats.size() != 0 && $urandom % 2 == 1) begin
			mem_data_valid = 1'b1;
			mem_data       = beats.pop_front();
		end
		if (busy_last && !busy && (exp_cmds.size() != 0 || beats.size() != 0))
			stop_on_error("busy fell while reads of the job were still outstanding");
		busy_last = busy;
	endtask

	initial begin
		int   j;
		int   waited;
		int   total;
		logic room_at_start;
		void'($urandom(56));
		clock          = 1'b0;
		rstn           = 1'b0;
		job_start      = 1'b0;
		job            = '0;
		cmd_grant      = 1'b0;
		mem_data_valid = 1'b0;
		mem_data       = '0;
		vertex_request = 1'b0;
		grant_armed    = 1'b0;
		reverse_data   = 1'b0;
		busy_last      = 1'b0;
		grant_delay    = 0;
		issued         = 0;
		popped         = 0;
		stall_cycles   = 0;
		cycles         = 0;
		total          = 0;
		load_stim();
		for (j = 0; j < jobs.size(); j++)
			total += int'(jobs[j].count);
		cycle_limit = 200 + 40 * total;
		repeat (10) @(negedge clock);
		if (cmd_req !== 1'b0 || busy !== 1'b0 || vertex_valid !== 1'b0)
			stop_on_error($sformatf("MISMATCH at %0t: reset outputs expected 000 got %b%b%b",
				$time, cmd_req, busy, vertex_valid));
		rstn = 1'b1;
		// third job stalls the consumer and returns edges before degree
		for (j = 0; j < jobs.size(); j++) begin
			build_expected(jobs[j]);
			stall_cycles = (j == 2) ? 100 : 0;
			reverse_data = (j == 2);
			// vertices of the job before may still fill the queue
			room_at_start = (issued - popped) <= `VTX_FIFO_DEPTH - `VTX_PER_LINE;
			job          = jobs[j];
			job_start    = 1'b1;
			step_cycle();
			job_start = 1'b0;
			if (busy !== 1'b1)
				stop_on_error("busy did not rise one cycle after job_start");
			waited = 0;
			while (room_at_start && !cmd_req) begin
				if (waited == 3)
					stop_on_error("cmd_req did not rise within 3 cycles of job_start");
				step_cycle();
				waited++;
			end
			// next job goes in as soon as busy falls
			while (busy)
				step_cycle();
		end
		while (exp_vertices.size() != 0)
			step_cycle();
		// extra pops would find any vertex beyond the last job
		repeat (4 * `VTX_PER_LINE)
			step_cycle();
		$display("Regression passed");
		$finish;
	end

endmodule

// File: test/vertex_stim.txt
# M <line byte address> <128-bit line, word 0 in the low bits>
# J <degree base> <edges base> <count> <first id> <cached>
M 00001000 1d0000031d0000021d0000011d000000
M 00001010 1d0000071d0000061d0000051d000004
M 00001020 1d00000b1d00000a1d0000091d000008
M 00002000 e0000003e0000002e0000001e0000000
M 00002010 e0000007e0000006e0000005e0000004
M 00002020 e000000be000000ae0000009e0000008
M 00003000 2d0000032d0000022d0000012d000000
M 00003010 2d0000072d0000062d0000052d000004
M 00004000 f0000003f0000002f0000001f0000000
M 00004010 f0000007f0000006f0000005f0000004
J 00001000 00002000 000a 0100 1
J 00003000 00004000 0006 0200 0
J 00001000 00002000 0016 0300 0

// File: all.f
+incdir+hdl
hdl/mem_cmd_pkg.sv
hdl/vertex_job_pkg.sv
hdl/vertex_read_sequencer.sv
hdl/vertex_line_unpacker.sv
hdl/vertex_job_fifo.sv
hdl/cu_vertex_job_control.sv
test/tb_vertex_job_control.sv

// File: Bender.yml
package:
  name: cu_vertex_job_control

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mem_cmd_pkg.sv
      - hdl/vertex_job_pkg.sv
      - hdl/vertex_read_sequencer.sv
      - hdl/vertex_line_unpacker.sv
      - hdl/vertex_job_fifo.sv
      - hdl/cu_vertex_job_control.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/tb_vertex_job_control.sv
